// ==== source/sysio_params.svh ====
`ifndef SYSIO_PARAMS_SVH
`define SYSIO_PARAMS_SVH

// ------------------------------
// cpu bus
// ------------------------------
`define SYSIO_AW 32 // address bits
`define SYSIO_DW 32 // data bits, one select per byte

// ------------------------------
// address map
// ------------------------------
// io pages, matched on adr[31:8]
`define SYSIO_LEDS_BASE 24'hFD0FFF
`define SYSIO_RST_BASE 24'hFD0FFC
`define SYSIO_TMR_BASE 24'hFD0FFB
// scratch area, matched on adr[31:20]
`define SYSIO_SCR_BASE 12'h001
`define SYSIO_SCR_DEPTH 256 // words, indexed by adr[9:2]

// node reset / clock enable
`define SYSIO_RST_PULSE 64 // cycles a reset mask stays on
`define SYSIO_CLKEN_INIT 3'b110

// timer tick
`define SYSIO_TMR_W 24 // counter bits
`define SYSIO_TMR_WRAP 1000000
`define SYSIO_TMR_ON 150
`define SYSIO_TMR_OFF 200

`endif

// ==== source/sysio_pkg.sv ====
`default_nettype none

package sysio_pkg;

	// ------------------------------
	// decoded target of an access
	// ------------------------------
	typedef enum logic [2:0] {
		REG_NONE = 3'd0, // nothing mapped, answers with err
		REG_LEDS = 3'd1, // led register
		REG_RST  = 3'd2, // node reset and clock enables
		REG_TMR  = 3'd3, // timer counter, read only
		REG_SCR  = 3'd4  // scratch memory
	} region_t;

	// ------------------------------
	// operation issued this cycle
	// ------------------------------
	// one non-idle op per strobe, decode
	// holds idle for the rest of it
	typedef enum logic [1:0] {
		OP_IDLE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} bus_op_t;

endpackage

`default_nettype wire

// ==== source/sysio_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysio_params.svh"

module sysio_decode (
	input  wire                 clk100,
	input  wire                 rst,
	input  wire                 cyc_i,
	input  wire                 stb_i,
	input  wire                 we_i,
	input  wire [`SYSIO_AW-1:0] adr_i,
	output sysio_pkg::bus_op_t  op_o,     // valid for one cycle per strobe
	output sysio_pkg::region_t  region_o  // target of the current address
);
	import sysio_pkg::*;

	logic taken; // op already issued for this strobe
	logic req;   // first cycle of a strobe

	assign req = cyc_i & stb_i & ~taken;

	// ------------------------------
	// address classification
	// ------------------------------
	always_comb begin
		region_o = REG_NONE; // unmapped unless a page matches
		if (adr_i[`SYSIO_AW-1:8] == `SYSIO_LEDS_BASE)
			region_o = REG_LEDS;
		else if (adr_i[`SYSIO_AW-1:8] == `SYSIO_RST_BASE)
			region_o = REG_RST;
		else if (adr_i[`SYSIO_AW-1:8] == `SYSIO_TMR_BASE)
			region_o = REG_TMR;
		else if (adr_i[`SYSIO_AW-1:20] == `SYSIO_SCR_BASE)
			region_o = REG_SCR; // 1 MB window, only low 1 KB backed
	end

	// ------------------------------
	// op issue
	// ------------------------------
	always_comb begin
		op_o = OP_IDLE;
		if (req)
			op_o = we_i ? OP_WRITE : OP_READ;
	end

	// set on issue, held while stb stays up
	always_ff @(posedge clk100) begin
		if (rst)
			taken <= 1'b0;
		else if (!stb_i)
			taken <= 1'b0; // master dropped stb, ready for next
		else if (op_o != OP_IDLE)
			taken <= 1'b1;
	end

	// a long strobe never yields back to back ops
	a_one_op_per_strobe: assert property (
		@(posedge clk100) disable iff (rst)
		(op_o != OP_IDLE) |=> (op_o == OP_IDLE)
	) else $error("decode issued ops on consecutive cycles");

endmodule

`default_nettype wire

// ==== source/sysio_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysio_params.svh"

module sysio_execute (
	input  wire                   clk100,
	input  wire                   rst,
	input  sysio_pkg::bus_op_t    op_i,
	input  sysio_pkg::region_t    region_i,
	input  wire [`SYSIO_DW/8-1:0] sel_i,
	input  wire [`SYSIO_AW-1:0]   adr_i,
	input  wire [`SYSIO_DW-1:0]   dat_i,
	output logic [`SYSIO_DW-1:0]  rdata_o,    // read value, registered
	output logic [7:0]            led_o,
	output logic [15:0]           node_rst_o, // per node reset pulse
	output logic [2:0]            clken_o,    // node clock enables
	output logic                  irq_o       // timer tick
);
	import sysio_pkg::*;

	localparam int SCR_AW = $clog2(`SYSIO_SCR_DEPTH); // word index bits
	localparam int RCW = $clog2(`SYSIO_RST_PULSE) + 1; // room for the end count
	localparam logic [RCW-1:0] RST_END = RCW'(`SYSIO_RST_PULSE);
	localparam logic [RCW-1:0] RST_LAST = RCW'(`SYSIO_RST_PULSE - 1);

	logic wr; // write op this cycle
	logic rd; // read op this cycle
	logic [SCR_AW-1:0] scr_idx;
	logic [RCW-1:0] rst_cnt; // cycles since the mask was written
	logic rst_done;
	logic [`SYSIO_TMR_W-1:0] icnt;
	logic [`SYSIO_DW-1:0] scr_mem [0:`SYSIO_SCR_DEPTH-1];

	assign wr = (op_i == OP_WRITE);
	assign rd = (op_i == OP_READ);
	assign scr_idx = adr_i[SCR_AW+1:2]; // word address
	assign rst_done = (rst_cnt == RST_END);

	// ------------------------------
	// led register
	// ------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			led_o <= 8'h00;
		else if (wr && region_i == REG_LEDS)
			led_o <= dat_i[7:0]; // low byte only, selects ignored
	end

	// ------------------------------
	// node reset / clock enable
	// ------------------------------
	// low half holds the reset mask, bits 18..16 the clock enables
	always_ff @(posedge clk100) begin
		if (rst) begin
			rst_cnt <= RST_END; // starts out finished
			node_rst_o <= 16'h0000;
			clken_o <= `SYSIO_CLKEN_INIT;
		end else begin
			if (!rst_done) begin
				rst_cnt <= rst_cnt + 1'b1;
				if (rst_cnt == RST_LAST)
					node_rst_o <= 16'h0000; // pulse ends by itself
			end
			if (wr && region_i == REG_RST) begin
				if (|sel_i[1:0]) begin
					node_rst_o <= dat_i[15:0];
					rst_cnt <= '0; // restart pulse
				end
				if (|sel_i[3:2])
					clken_o <= dat_i[18:16];
			end
		end
	end

	// mask clears on the same edge the count runs out
	a_rst_pulse_ends: assert property (
		@(posedge clk100) disable iff (rst)
		rst_done |-> (node_rst_o == 16'h0000)
	) else $error("node reset still driven after pulse end");

	// ------------------------------
	// timer
	// ------------------------------
	// free running, irq on from ON to OFF each period
	always_ff @(posedge clk100) begin
		if (rst) begin
			icnt <= `SYSIO_TMR_W'(1);
			irq_o <= 1'b0;
		end else begin
			if (icnt == `SYSIO_TMR_WRAP)
				icnt <= `SYSIO_TMR_W'(1); // wrap
			else
				icnt <= icnt + 1'b1;
			if (icnt == `SYSIO_TMR_ON)
				irq_o <= 1'b1;
			else if (icnt == `SYSIO_TMR_OFF)
				irq_o <= 1'b0;
		end
	end

	// ------------------------------
	// scratch memory
	// ------------------------------
	always_ff @(posedge clk100) begin
		if (wr && region_i == REG_SCR) begin
			for (int b = 0; b < `SYSIO_DW/8; b++) begin
				if (sel_i[b])
					scr_mem[scr_idx][b*8 +: 8] <= dat_i[b*8 +: 8]; // byte lane
			end
		end
	end

	// ------------------------------
	// read value
	// ------------------------------
	// captured on the op edge, result presents it with the ack
	always_ff @(posedge clk100) begin
		if (rd) begin
			case (region_i)
				REG_LEDS: rdata_o <= `SYSIO_DW'(led_o);
				REG_RST:  rdata_o <= `SYSIO_DW'({clken_o, node_rst_o});
				REG_TMR:  rdata_o <= `SYSIO_DW'(icnt);
				REG_SCR:  rdata_o <= scr_mem[scr_idx];
				default:  rdata_o <= '0; // unmapped, result sends err
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/sysio_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysio_params.svh"

module sysio_result (
	input  wire                  clk100,
	input  wire                  rst,
	input  sysio_pkg::bus_op_t   op_i,
	input  sysio_pkg::region_t   region_i,
	input  wire [`SYSIO_DW-1:0]  rdata_i, // registered by execute
	output logic                 ack_o,
	output logic                 err_o,
	output logic [`SYSIO_DW-1:0] dat_o
);
	import sysio_pkg::*;

	logic issued; // op present this cycle
	logic mapped; // address hits a target
	logic rd_q;   // answering a read next cycle

	assign issued = (op_i != OP_IDLE);
	assign mapped = (region_i != REG_NONE);

	// ------------------------------
	// response flags
	// ------------------------------
	// registered on the op edge, so the answer
	// lands one cycle after the strobe starts
	always_ff @(posedge clk100) begin
		if (rst) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			ack_o <= issued & mapped;
			err_o <= issued & ~mapped; // unmapped address
			rd_q <= (op_i == OP_READ) & mapped;
		end
	end

	// ------------------------------
	// read data return
	// ------------------------------
	// bus stays at zero except alongside a read ack
	assign dat_o = rd_q ? rdata_i : '0;

	// ------------------------------
	// checks
	// ------------------------------
	a_ack_err_excl: assert property (
		@(posedge clk100) disable iff (rst)
		!(ack_o && err_o)
	) else $error("ack and err raised together");

	// decode issues once per strobe, so every answer is a single cycle
	a_answer_pulse: assert property (
		@(posedge clk100) disable iff (rst)
		(ack_o || err_o) |=> !(ack_o || err_o)
	) else $error("answer held longer than one cycle");

endmodule

`default_nettype wire

// ==== source/sysio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysio_params.svh"

module sysio_top (
	input  wire                   clk100,
	input  wire                   rst,
	// cpu bus, slave side
	input  wire                   cyc_i,
	input  wire                   stb_i,
	input  wire                   we_i,
	input  wire [`SYSIO_DW/8-1:0] sel_i,
	input  wire [`SYSIO_AW-1:0]   adr_i,
	input  wire [`SYSIO_DW-1:0]   dat_i,
	output wire                   ack_o,
	output wire                   err_o,
	output wire [`SYSIO_DW-1:0]   dat_o,
	// board / node side
	output wire [7:0]             led_o,
	output wire [15:0]            node_rst_o,
	output wire [2:0]             clken_o,
	output wire                   irq_o
);
	import sysio_pkg::*;

	// ------------------------------
	// stage to stage wires
	// ------------------------------
	bus_op_t op;       // decode -> execute, result
	region_t region;   // decode -> execute, result
	wire [`SYSIO_DW-1:0] rdata; // execute -> result

	// ------------------------------
	// decode
	// ------------------------------
	sysio_decode u_decode (
		.clk100   (clk100),
		.rst      (rst),
		.cyc_i    (cyc_i),
		.stb_i    (stb_i),
		.we_i     (we_i),
		.adr_i    (adr_i),
		.op_o     (op),
		.region_o (region)
	);

	// ------------------------------
	// execute
	// ------------------------------
	sysio_execute u_execute (
		.clk100     (clk100),
		.rst        (rst),
		.op_i       (op),
		.region_i   (region),
		.sel_i      (sel_i),
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.rdata_o    (rdata),
		.led_o      (led_o),
		.node_rst_o (node_rst_o),
		.clken_o    (clken_o),
		.irq_o      (irq_o)
	);

	// ------------------------------
	// result
	// ------------------------------
	sysio_result u_result (
		.clk100   (clk100),
		.rst      (rst),
		.op_i     (op),
		.region_i (region),
		.rdata_i  (rdata),
		.ack_o    (ack_o),
		.err_o    (err_o),
		.dat_o    (dat_o)
	);

endmodule

`default_nettype wire

// ==== bench/sysio_tb_checks.svh ====
`ifndef SYSIO_TB_CHECKS_SVH
`define SYSIO_TB_CHECKS_SVH

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_data(input string what, input logic [`SYSIO_DW-1:0] exp,
	input logic [`SYSIO_DW-1:0] act);
	n_checks++;
	if (act !== exp) begin
		$display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
		test_errs++;
	end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	n_checks++;
	if (act !== exp) begin
		$display("FAIL %s: %s expected %b actual %b", cur_test, what, exp, act);
		test_errs++;
	end
endtask

task automatic check_region_bits(input string what, input region_t exp, input region_t act);
	n_checks++;
	if (act !== exp) begin
		$display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
		test_errs++;
	end
endtask

// ------------------------------
// bus master
// ------------------------------
// one request, answer awaited with a limit, stb kept up for hold extra cycles
task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
	input logic [31:0] dat, input int hold);
	req_t r;
	int lat;
	r.op = we ? OP_WRITE : OP_READ;
	r.sel = sel;
	r.adr = adr;
	r.dat = dat;
	pend_q.push_back(r); // comparer pops it with the answer
	cyc_i = 1'b1;
	stb_i = 1'b1;
	we_i = we;
	sel_i = sel;
	adr_i = adr;
	dat_i = dat;
	#4; // mid cycle, decode settled
	check_region_bits("decoded region", ref_region(adr), uut.region);
	lat = 0;
	do begin
		@(posedge clk100);
		#1;
		lat++;
	end while (!(ack_o || err_o) && lat < ANSWER_WAIT);
	if (!(ack_o || err_o)) begin
		$display("FAIL %s: no answer from the DUT within %0d cycles", cur_test, lat);
		test_errs++;
		pend_q.delete();
	end else
		check_flag("answer one cycle after strobe", 1'b1, lat == 1);
	repeat (hold) begin
		@(posedge clk100); // stb still up, no second answer allowed
		#1;
	end
	cyc_i = 1'b0;
	stb_i = 1'b0;
	we_i = 1'b0;
	wait_cycles(1); // idle gap before next strobe
endtask

task automatic bus_write(input logic [3:0] sel, input logic [31:0] adr, input logic [31:0] dat);
	bus_access(1'b1, sel, adr, dat, 0);
endtask

task automatic bus_read(input logic [31:0] adr);
	bus_access(1'b0, 4'hf, adr, '0, 0);
endtask

`endif

// ==== bench/sysio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysio_params.svh"

module sysio_tb;
	import sysio_pkg::*;

	localparam logic [31:0] SEED = 32'hc304fa62;
	localparam int ANSWER_WAIT = 8; // cycles before a missing answer counts as an error
	localparam int CYC_REQ = 3;     // per access, idle gap included
	localparam int N_LED = 8;
	localparam int N_SCR = 48;
	localparam int N_RST = 4;
	localparam int N_UNMAP = 12;
	localparam int N_HOLD = 6;
	localparam int TMR_END = `SYSIO_TMR_OFF + 10; // just past the irq window
	localparam int RUN_LIMIT = 2 + TMR_END + CYC_REQ + N_LED * 2 * CYC_REQ
		+ (`SYSIO_SCR_DEPTH + 2 * N_SCR) * CYC_REQ
		+ N_RST * (3 * CYC_REQ + `SYSIO_RST_PULSE + 4)
		+ (N_UNMAP + 1) * CYC_REQ + N_HOLD * (CYC_REQ + 4) + 100;
	localparam logic [31:0] LED_ADR = {`SYSIO_LEDS_BASE, 8'h00};
	localparam logic [31:0] RST_ADR = {`SYSIO_RST_BASE, 8'h00};
	localparam logic [31:0] TMR_ADR = {`SYSIO_TMR_BASE, 8'h00};

	typedef struct packed {
		bus_op_t op;
		logic [3:0] sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} req_t;

	logic clk100;
	logic rst;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	logic [3:0] sel_i;
	logic [`SYSIO_AW-1:0] adr_i;
	logic [`SYSIO_DW-1:0] dat_i;
	wire ack_o;
	wire err_o;
	wire [`SYSIO_DW-1:0] dat_o;
	wire [7:0] led_o;
	wire [15:0] node_rst_o;
	wire [2:0] clken_o;
	wire irq_o;

	logic [31:0] lfsr;
	int tick;        // edges since reset release
	int run_cycles;
	string cur_test;
	int test_errs;
	int n_checks;
	int n_pass;
	int n_fail;
	req_t pend_q[$]; // issued, not yet answered

	// reference model state
	logic [7:0] ref_led;
	logic [15:0] ref_mask;
	int ref_mask_tick; // edge that stored the mask
	logic [2:0] ref_clken;
	logic [31:0] ref_mem [0:`SYSIO_SCR_DEPTH-1];
	logic [3:0] rst_sels [0:N_RST-1] = '{4'b0011, 4'b1100, 4'b1111, 4'b0001};

	initial begin
		clk100 = 1'b0;
		forever #5 clk100 = ~clk100;
	end

	sysio_top uut (
		.clk100     (clk100),
		.rst        (rst),
		.cyc_i      (cyc_i),
		.stb_i      (stb_i),
		.we_i       (we_i),
		.sel_i      (sel_i),
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.ack_o      (ack_o),
		.err_o      (err_o),
		.dat_o      (dat_o),
		.led_o      (led_o),
		.node_rst_o (node_rst_o),
		.clken_o    (clken_o),
		.irq_o      (irq_o)
	);

	always @(posedge clk100) begin
		run_cycles <= run_cycles + 1;
		if (!rst)
			tick <= tick + 1;
		if (run_cycles >= RUN_LIMIT) begin
			$display("timeout: run still going after %0d cycles", RUN_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ------------------------------
	// random source and reference
	// ------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32+x^22+x^2+x+1
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic region_t ref_region(input logic [31:0] adr);
		if (adr[31:8] == `SYSIO_LEDS_BASE)
			return REG_LEDS;
		if (adr[31:8] == `SYSIO_RST_BASE)
			return REG_RST;
		if (adr[31:8] == `SYSIO_TMR_BASE)
			return REG_TMR;
		if (adr[31:20] == `SYSIO_SCR_BASE)
			return REG_SCR;
		return REG_NONE;
	endfunction

	// mask stays for the write edge plus the next 63
	function automatic logic [15:0] ref_node_rst(input int t);
		return (t - ref_mask_tick < `SYSIO_RST_PULSE) ? ref_mask : 16'h0000;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c96e1;
	endfunction

	// applies a write, or returns what a read at op edge t should see
	function automatic logic [31:0] ref_access(input bus_op_t op, input logic [3:0] sel,
		input logic [31:0] adr, input logic [31:0] dat, input int t);
		logic [7:0] idx;
		logic [31:0] rd;
		idx = adr[9:2];
		rd = '0;
		if (op == OP_READ) begin
			case (ref_region(adr))
				REG_LEDS: rd = {24'h0, ref_led};
				REG_RST:  rd = {13'h0, ref_clken, ref_node_rst(t - 1)}; // value before the edge
				REG_TMR:  rd = 32'(t); // counter starts at 1, no wrap this early
				REG_SCR:  rd = ref_mem[idx];
				default:  rd = '0;
			endcase
		end else if (ref_region(adr) == REG_LEDS)
			ref_led = dat[7:0];
		else if (ref_region(adr) == REG_RST) begin
			if (|sel[1:0]) begin
				ref_mask = dat[15:0];
				ref_mask_tick = t;
			end
			if (|sel[3:2])
				ref_clken = dat[18:16];
		end else if (ref_region(adr) == REG_SCR) begin
			for (int b = 0; b < 4; b++)
				if (sel[b])
					ref_mem[idx][b*8 +: 8] = dat[b*8 +: 8]; // unselected lanes keep
		end
		return rd;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk100);
			#1;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("PASS %s", cur_test);
			n_pass++;
		end else begin
			$display("FAIL %s: %0d errors", cur_test, test_errs);
			n_fail++;
		end
		test_errs = 0;
	endtask

	`include "sysio_tb_checks.svh"

	// ------------------------------
	// comparing process
	// ------------------------------
	// 2 ns after each edge, clear of stimulus at 1 ns
	initial begin : compare
		req_t r;
		region_t rg;
		logic [31:0] exp_rd;
		logic rd_ans;
		forever begin
			@(posedge clk100);
			#2;
			if (tick > 0) begin
				rd_ans = 1'b0;
				if ((ack_o || err_o) && pend_q.size() == 0) begin
					$display("FAIL %s: answer from the DUT with no request pending", cur_test);
					test_errs++;
				end else if (ack_o || err_o) begin
					r = pend_q.pop_front();
					rg = ref_region(r.adr);
					exp_rd = ref_access(r.op, r.sel, r.adr, r.dat, tick);
					check_flag("ack_o", rg != REG_NONE, ack_o);
					check_flag("err_o", rg == REG_NONE, err_o);
					rd_ans = (r.op == OP_READ) && (rg != REG_NONE);
					if (rd_ans)
						check_data("read data", exp_rd, dat_o);
				end
				if (!rd_ans)
					check_data("dat_o between reads", '0, dat_o);
				check_data("led_o", ref_led, led_o);
				check_data("node_rst_o", ref_node_rst(tick), node_rst_o);
				check_data("clken_o", ref_clken, clken_o);
				check_flag("irq_o", tick >= `SYSIO_TMR_ON && tick < `SYSIO_TMR_OFF, irq_o);
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin : stimulus
		logic [31:0] a;
		rst = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
		lfsr = SEED;
		tick = 0;
		run_cycles = 0;
		test_errs = 0;
		n_checks = 0;
		n_pass = 0;
		n_fail = 0;
		ref_led = '0;
		ref_mask = '0;
		ref_mask_tick = -1000; // no pulse yet
		ref_clken = `SYSIO_CLKEN_INIT;
		repeat (2) @(posedge clk100);
		#1;
		rst = 1'b0;

		start_test("reset_and_timer");
		check_data("led_o after reset", '0, led_o);
		check_data("node_rst_o after reset", '0, node_rst_o);
		check_data("clken_o after reset", `SYSIO_CLKEN_INIT, clken_o);
		while (tick < TMR_END)
			wait_cycles(1); // irq window watched by the comparer
		bus_read(TMR_ADR);
		end_test();

		start_test("led_register");
		for (int i = 0; i < N_LED; i++) begin
			a = {`SYSIO_LEDS_BASE, 6'(rand_bits(6)), 2'b00};
			bus_write(4'(rand_bits(4)), a, rand_bits(32));
			bus_read(a);
		end
		end_test();

		start_test("scratch_memory");
		for (int k = 0; k < `SYSIO_SCR_DEPTH; k++) begin
			a = {`SYSIO_SCR_BASE, 10'h000, 8'(k), 2'b00};
			bus_write(4'hf, a, fill_word(a));
		end
		for (int i = 0; i < N_SCR; i++) begin
			a = {`SYSIO_SCR_BASE, 18'(rand_bits(18)), 2'b00};
			bus_write(4'(rand_bits(4)), a, rand_bits(32));
			bus_read({a[31:20], 10'(rand_bits(10)), a[9:0]}); // same word, other alias
		end
		end_test();

		start_test("reset_register");
		for (int i = 0; i < N_RST; i++) begin
			bus_write(rst_sels[i], RST_ADR, rand_bits(32));
			bus_read(RST_ADR); // pulse running
			wait_cycles(`SYSIO_RST_PULSE + 4);
			bus_read(RST_ADR); // pulse over
		end
		end_test();

		start_test("unmapped_address");
		for (int i = 0; i < N_UNMAP; i++) begin
			a = {30'(rand_bits(30)), 2'b00};
			while (ref_region(a) != REG_NONE)
				a = {30'(rand_bits(30)), 2'b00};
			bus_access(i[0], 4'(rand_bits(4)), a, rand_bits(32), 0);
		end
		bus_read(LED_ADR);
		end_test();

		start_test("one_answer_per_strobe");
		for (int i = 0; i < N_HOLD; i++) begin
			case (i % 3)
				0: a = LED_ADR;
				1: a = {`SYSIO_SCR_BASE, 18'(rand_bits(18)), 2'b00};
				default: a = {8'ha5, 22'(rand_bits(22)), 2'b00}; // unmapped, err
			endcase
			bus_access(i[1], 4'hf, a, rand_bits(32), 1 + int'(rand_bits(2)));
		end
		end_test();

		$display("tests: %0d passed, %0d failed, %0d checks", n_pass, n_fail, n_checks);
		if (n_fail == 0 && test_errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
+incdir+bench
source/sysio_pkg.sv
source/sysio_decode.sv
source/sysio_execute.sv
source/sysio_result.sv
source/sysio_top.sv
bench/sysio_tb.sv
